// File: common/gem_tx_consts.svh
`ifndef GEM_TX_CONSTS_SVH
`define GEM_TX_CONSTS_SVH

// ---------------------------------------------------------------------
// Link and frame geometry
// ---------------------------------------------------------------------
`define GEM_N_LINKS       4         // Trigger links per front end
`define GEM_FRAME_WORDS   5         // Separator, three data words, CRC
`define GEM_LINK_BITS     56        // Payload bits carried by one link
`define GEM_DATA_BITS     112       // Two link halves
`define GEM_WORD_BITS     16        // Transceiver word
`define GEM_ISK_BITS      2         // One char-is-K flag per byte
`define GEM_CRC_BITS      8

`define GEM_IDLE_WORD     16'hFFFC  // K.28.7 in low byte, filler above
`define GEM_IDLE_ISK      2'b01

// Separator K-codes
`define GEM_K_BC0         8'hBC     // K.28.5
`define GEM_K_RESYNC      8'h3C     // K.28.1
`define GEM_K_OVERFLOW    8'hFE     // K.30.7
`define GEM_K_BX0         8'h1C     // K.28.0
`define GEM_K_BX1         8'hF7     // K.23.7
`define GEM_K_BX2         8'hFB     // K.27.7
`define GEM_K_BX3         8'hFD     // K.29.7

`define GEM_CRC_POLY      8'h07     // x^8 + x^2 + x + 1, seed zero, MSB first

// Startup and ready timing, in clock_40 cycles or frames
`define GEM_LINK_BASE     32        // Release of link 0
`define GEM_LINK_STEP     64        // Gap between link releases
`define GEM_STARTUP_DONE  320
`define GEM_READY_FRAMES  8         // Good frames in a row before ready

`endif

// File: common/gem_tx_pkg.sv
`include "gem_tx_consts.svh"

package gem_tx_pkg;

   // Slot of the current word inside a five-word frame
   typedef enum logic [2:0] {
      WORD_SEP = 3'd0,  // Separator K-code plus data 7:0
      WORD_D1  = 3'd1,
      WORD_D2  = 3'd2,
      WORD_D3  = 3'd3,
      WORD_CRC = 3'd4   // CRC-8 in the low byte
   } frame_word_t;

   // Frame separator characters
   typedef enum logic [7:0] {
      K_BC0      = `GEM_K_BC0,
      K_RESYNC   = `GEM_K_RESYNC,
      K_OVERFLOW = `GEM_K_OVERFLOW,
      K_BX0      = `GEM_K_BX0,      // Rotating codes, picked by bunch counter
      K_BX1      = `GEM_K_BX1,
      K_BX2      = `GEM_K_BX2,
      K_BX3      = `GEM_K_BX3
   } k_code_t;

   typedef logic [`GEM_WORD_BITS-1:0] link_word_t;
   typedef logic [`GEM_ISK_BITS-1:0]  link_isk_t;
   typedef logic [`GEM_CRC_BITS-1:0]  crc_t;
   typedef logic [`GEM_LINK_BITS-1:0] link_data_t;  // One link's half of the frame

endpackage

// File: link/gem_link_crc8.sv
`include "gem_tx_consts.svh"

module gem_link_crc8 (
   input  logic                    clock_40,
   input  logic                    arst_n_i,
   input  gem_tx_pkg::link_word_t  word_i,
   input  logic                    en_i,
   input  logic                    clr_i,
   output gem_tx_pkg::crc_t        crc_o
);

   import gem_tx_pkg::*;

   crc_t crc_q;

   // Sixteen serial CRC steps, word MSB first
   function automatic crc_t crc_step(input crc_t crc_in, input link_word_t word);
      crc_t c;
      int   bit_idx;
      c = crc_in;
      for (bit_idx = `GEM_WORD_BITS - 1; bit_idx >= 0; bit_idx--) begin
         if (c[`GEM_CRC_BITS-1] ^ word[bit_idx])
            c = {c[`GEM_CRC_BITS-2:0], 1'b0} ^ `GEM_CRC_POLY;
         else
            c = {c[`GEM_CRC_BITS-2:0], 1'b0};
      end
      return c;
   endfunction

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i)
         crc_q <= '0;
      else if (clr_i)
         crc_q <= '0;                     // Clear wins, seed is zero
      else if (en_i)
         crc_q <= crc_step(crc_q, word_i);
   end

   assign crc_o = crc_q;

endmodule

// File: link/gem_link_framer.sv
`include "gem_tx_consts.svh"

module gem_link_framer #(
   parameter int LINK_IDX = 0  // Even links carry the low half, odd the high half
) (
   input  logic                        clock_40,
   input  logic                        arst_n_i,
   input  logic                        link_en_i,
   input  gem_tx_pkg::frame_word_t     frame_word_i,
   input  logic                        frame_active_i,
   input  gem_tx_pkg::k_code_t         sep_code_i,
   input  logic [`GEM_DATA_BITS-1:0]   gem_data_i,
   output gem_tx_pkg::link_word_t      tx_data_o,
   output gem_tx_pkg::link_isk_t       tx_isk_o,
   output logic                        frame_done_o
);

   import gem_tx_pkg::*;

   link_data_t    link_data;
   link_word_t    word_nxt;
   link_isk_t     isk_nxt;
   logic          send;      // Link up and a frame in flight
   crc_t          crc;

   if (LINK_IDX % 2 == 0) begin : g_low_half
      assign link_data = gem_data_i[`GEM_LINK_BITS-1:0];
   end else begin : g_high_half
      assign link_data = gem_data_i[`GEM_DATA_BITS-1:`GEM_LINK_BITS];
   end

   assign send = link_en_i && frame_active_i;

   // ---------------------------------------------------------------------
   // Word multiplexer
   // ---------------------------------------------------------------------
   always_comb begin
      word_nxt = `GEM_IDLE_WORD;   // Idle unless a frame is going out
      isk_nxt  = `GEM_IDLE_ISK;
      if (send) begin
         case (frame_word_i)
            WORD_SEP: begin
               word_nxt = {link_data[7:0], sep_code_i};
               isk_nxt  = 2'b01;                      // K-code in low byte
            end
            WORD_D1: begin
               word_nxt = link_data[23:8];
               isk_nxt  = 2'b00;
            end
            WORD_D2: begin
               word_nxt = link_data[39:24];
               isk_nxt  = 2'b00;
            end
            WORD_D3: begin
               word_nxt = link_data[55:40];
               isk_nxt  = 2'b00;
            end
            WORD_CRC: begin
               word_nxt = {{(`GEM_WORD_BITS-`GEM_CRC_BITS){1'b0}}, crc};
               isk_nxt  = 2'b00;
            end
            default: ;                                 // Keep idle
         endcase
      end
   end

   // CRC sees words 0 to 3 as they are registered, restarts every period
   gem_link_crc8 u_crc (
      .clock_40 (clock_40),
      .arst_n_i (arst_n_i),
      .word_i   (word_nxt),
      .en_i     (send && (frame_word_i != WORD_CRC)),
      .clr_i    (frame_word_i == WORD_CRC),
      .crc_o    (crc)
   );

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_data_o <= `GEM_IDLE_WORD;
         tx_isk_o  <= `GEM_IDLE_ISK;
      end else begin
         tx_data_o <= word_nxt;
         tx_isk_o  <= isk_nxt;
      end
   end

   // High while the CRC word goes into the output register
   assign frame_done_o = send && (frame_word_i == WORD_CRC);

   // A K-flagged word that is not idle must have been a separator slot
   a_isk_sep : assert property (@(posedge clock_40) disable iff (!arst_n_i)
      (tx_isk_o == 2'b01 && tx_data_o != `GEM_IDLE_WORD) |-> ($past(frame_word_i) == WORD_SEP))
      else $error("link %0d: K mask on non-separator word %h", LINK_IDX, tx_data_o);

endmodule

// File: hw/gem_frame_stage.sv
`include "gem_tx_consts.svh"

module gem_frame_stage (
   input  logic                        clock_40,
   input  logic                        arst_n_i,
   input  logic                        startup_done_i,
   input  logic                        frame_valid_i,
   input  logic [`GEM_DATA_BITS-1:0]   gem_data_i,
   input  logic                        overflow_i,
   input  logic                        bc0_i,
   input  logic                        resync_i,
   input  logic [1:0]                  bxn_lsbs_i,
   output logic                        frame_ready_o,
   output gem_tx_pkg::frame_word_t     frame_word_o,
   output logic                        frame_active_o,
   output gem_tx_pkg::k_code_t         sep_code_o,
   output logic [`GEM_DATA_BITS-1:0]   gem_data_o
);

   import gem_tx_pkg::*;

   frame_word_t                  frame_word_q;   // Free-running slot counter
   frame_word_t                  frame_word_nxt;
   logic                         frame_active_q;
   logic                         accept;
   k_code_t                      sep_nxt;
   k_code_t                      sep_code_q;
   logic [`GEM_DATA_BITS-1:0]    gem_data_q;

   // Only the last slot of a period can take a new frame
   assign frame_ready_o = startup_done_i && (frame_word_q == WORD_CRC);
   assign accept        = frame_valid_i && frame_ready_o;

   // ---------------------------------------------------------------------
   // Slot counter and frame handshake
   // ---------------------------------------------------------------------
   always_comb begin
      case (frame_word_q)
         WORD_SEP: frame_word_nxt = WORD_D1;
         WORD_D1:  frame_word_nxt = WORD_D2;
         WORD_D2:  frame_word_nxt = WORD_D3;
         WORD_D3:  frame_word_nxt = WORD_CRC;
         default:  frame_word_nxt = WORD_SEP;  // Wrap after the CRC slot
      endcase
   end

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         frame_word_q   <= WORD_SEP;
         frame_active_q <= 1'b0;
      end else begin
         frame_word_q <= frame_word_nxt;
         if (frame_word_q == WORD_CRC)
            frame_active_q <= accept;  // No frame taken means an idle period
      end
   end

   // Separator priority: bc0, resync, overflow, then the bunch counter
   always_comb begin
      if (bc0_i)
         sep_nxt = K_BC0;
      else if (resync_i)
         sep_nxt = K_RESYNC;
      else if (overflow_i)
         sep_nxt = K_OVERFLOW;
      else begin
         case (bxn_lsbs_i)
            2'd0:    sep_nxt = K_BX0;
            2'd1:    sep_nxt = K_BX1;
            2'd2:    sep_nxt = K_BX2;
            default: sep_nxt = K_BX3;
         endcase
      end
   end

   // Payload capture on acceptance
   always_ff @(posedge clock_40) begin
      if (accept) begin
         gem_data_q <= gem_data_i;
         sep_code_q <= sep_nxt;
      end
   end

   assign frame_word_o   = frame_word_q;
   assign frame_active_o = frame_active_q;
   assign sep_code_o     = sep_code_q;
   assign gem_data_o     = gem_data_q;

   // Slot stays within the frame
   a_slot_range : assert property (@(posedge clock_40) disable iff (!arst_n_i)
      frame_word_q inside {WORD_SEP, WORD_D1, WORD_D2, WORD_D3, WORD_CRC})
      else $error("frame slot out of range: %0d", frame_word_q);

endmodule

// File: hw/gem_link_startup.sv
`include "gem_tx_consts.svh"

module gem_link_startup (
   input  logic                      clock_40,
   input  logic                      arst_n_i,
   input  logic [`GEM_N_LINKS-1:0]   link_reset_i,
   output logic [`GEM_N_LINKS-1:0]   link_en_o,
   output logic                      startup_done_o
);

   localparam int CNT_BITS = $clog2(`GEM_STARTUP_DONE + 1);
   localparam logic [CNT_BITS-1:0] DONE_CNT = CNT_BITS'(`GEM_STARTUP_DONE);

   logic [CNT_BITS-1:0]      startup_cnt_q;  // Saturates at the done count
   logic [`GEM_N_LINKS-1:0]  released;

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i)
         startup_cnt_q <= '0;
      else if (startup_cnt_q != DONE_CNT)
         startup_cnt_q <= startup_cnt_q + 1'b1;
   end

   // Staggered release, one link per step
   for (genvar i = 0; i < `GEM_N_LINKS; i++) begin : g_release
      localparam logic [CNT_BITS-1:0] RELEASE_CNT =
         CNT_BITS'(`GEM_LINK_BASE + i * `GEM_LINK_STEP);

      assign released[i] = (startup_cnt_q >= RELEASE_CNT);
   end

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         link_en_o      <= '0;
         startup_done_o <= 1'b0;
      end else begin
         link_en_o      <= released & ~link_reset_i;  // Per-link hold-off
         startup_done_o <= (startup_cnt_q == DONE_CNT);
      end
   end

endmodule

// File: hw/gem_ready_monitor.sv
`include "gem_tx_consts.svh"

module gem_ready_monitor (
   input  logic                      clock_40,
   input  logic                      arst_n_i,
   input  logic [`GEM_N_LINKS-1:0]   frame_done_i,
   input  gem_tx_pkg::frame_word_t   frame_word_i,
   input  logic                      force_not_ready_i,
   output logic                      ready_o
);

   import gem_tx_pkg::*;

   localparam int CNT_BITS = $clog2(`GEM_READY_FRAMES + 1);
   localparam logic [CNT_BITS-1:0] READY_CNT = CNT_BITS'(`GEM_READY_FRAMES);

   logic [CNT_BITS-1:0] good_cnt_q;  // Complete frames in a row

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i)
         good_cnt_q <= '0;
      else if (force_not_ready_i)
         good_cnt_q <= '0;
      else if (frame_word_i == WORD_CRC) begin
         if (&frame_done_i) begin
            if (good_cnt_q != READY_CNT)
               good_cnt_q <= good_cnt_q + 1'b1;   // Saturate at the limit
         end else
            good_cnt_q <= '0;                     // Idle period or a link down
      end
   end

   assign ready_o = (good_cnt_q == READY_CNT);

endmodule

// File: hw/gem_data_out.sv
`include "gem_tx_consts.svh"

module gem_data_out (
   input  logic                                        clock_40,
   input  logic                                        arst_n_i,
   input  logic                                        frame_valid_i,
   input  logic [`GEM_DATA_BITS-1:0]                   gem_data_i,
   input  logic                                        overflow_i,
   input  logic                                        bc0_i,
   input  logic                                        resync_i,
   input  logic [1:0]                                  bxn_lsbs_i,
   input  logic [`GEM_N_LINKS-1:0]                     link_reset_i,
   input  logic                                        force_not_ready_i,
   output logic [`GEM_N_LINKS*`GEM_WORD_BITS-1:0]      tx_data_o,   // Link i in slice i
   output logic [`GEM_N_LINKS*`GEM_ISK_BITS-1:0]       tx_isk_o,
   output logic                                        startup_done_o,
   output logic                                        frame_ready_o,
   output logic                                        ready_o
);

   import gem_tx_pkg::*;

   frame_word_t                frame_word;
   logic                       frame_active;
   k_code_t                    sep_code;
   logic [`GEM_DATA_BITS-1:0]  gem_data_q;      // Captured frame, shared by all links
   logic [`GEM_N_LINKS-1:0]    link_en;
   logic [`GEM_N_LINKS-1:0]    frame_done;

   // ---------------------------------------------------------------------
   // Frame stage and startup
   // ---------------------------------------------------------------------
   gem_frame_stage u_stage (
      .clock_40       (clock_40),
      .arst_n_i       (arst_n_i),
      .startup_done_i (startup_done_o),
      .frame_valid_i  (frame_valid_i),
      .gem_data_i     (gem_data_i),
      .overflow_i     (overflow_i),
      .bc0_i          (bc0_i),
      .resync_i       (resync_i),
      .bxn_lsbs_i     (bxn_lsbs_i),
      .frame_ready_o  (frame_ready_o),
      .frame_word_o   (frame_word),
      .frame_active_o (frame_active),
      .sep_code_o     (sep_code),
      .gem_data_o     (gem_data_q)
   );

   gem_link_startup u_startup (
      .clock_40       (clock_40),
      .arst_n_i       (arst_n_i),
      .link_reset_i   (link_reset_i),
      .link_en_o      (link_en),
      .startup_done_o (startup_done_o)
   );

   // ---------------------------------------------------------------------
   // Link framers
   // ---------------------------------------------------------------------
   for (genvar i = 0; i < `GEM_N_LINKS; i++) begin : g_link
      gem_link_framer #(.LINK_IDX(i)) u_framer (
         .clock_40       (clock_40),
         .arst_n_i       (arst_n_i),
         .link_en_i      (link_en[i]),
         .frame_word_i   (frame_word),
         .frame_active_i (frame_active),
         .sep_code_i     (sep_code),
         .gem_data_i     (gem_data_q),
         .tx_data_o      (tx_data_o[i*`GEM_WORD_BITS +: `GEM_WORD_BITS]),
         .tx_isk_o       (tx_isk_o[i*`GEM_ISK_BITS +: `GEM_ISK_BITS]),
         .frame_done_o   (frame_done[i])
      );
   end

   gem_ready_monitor u_ready (
      .clock_40          (clock_40),
      .arst_n_i          (arst_n_i),
      .frame_done_i      (frame_done),
      .frame_word_i      (frame_word),
      .force_not_ready_i (force_not_ready_i),
      .ready_o           (ready_o)
   );

endmodule

// File: test/tb_gem_model.svh
`ifndef TB_GEM_MODEL_SVH
`define TB_GEM_MODEL_SVH

// ---------------------------------------------------------------------
// Reference model state
// ---------------------------------------------------------------------
logic [`GEM_DATA_BITS-1:0] q_data[$];          // Accepted frames, oldest first
k_code_t                   q_sep[$];
int                        q_due[$];           // Edge that registers word 0
int                        edge_n;             // Edges since reset release
int                        m_slot;             // Slot before the edge
int                        m_scnt;             // Startup count
logic [`GEM_N_LINKS-1:0]   m_link_en;
logic                      m_sdone;
int                        m_good;             // Complete periods in a row
crc_t                      m_crc [`GEM_N_LINKS];
link_word_t                exp_word [`GEM_N_LINKS];
link_isk_t                 exp_isk [`GEM_N_LINKS];
logic                      exp_kchk [`GEM_N_LINKS];  // Word 0 on the line
k_code_t                   exp_sep;
logic                      exp_frame_ready;
logic                      exp_startup_done;
logic                      exp_ready;
k_code_t                   bx_codes [4] = '{K_BX0, K_BX1, K_BX2, K_BX3};

int err_word  = 0;
int err_isk   = 0;
int err_kcode = 0;
int err_ctrl  = 0;
int err_other = 0;

// CRC-8, poly 07, zero seed, high byte of the word first
function automatic crc_t model_crc8(input crc_t crc_in, input link_word_t w);
   crc_t c;
   int   n;
   c = crc_in;
   for (n = 1; n >= 0; n--) begin
      c = c ^ w[n*8 +: 8];
      repeat (8) c = c[7] ? ((c << 1) ^ `GEM_CRC_POLY) : (c << 1);
   end
   return c;
endfunction

function automatic k_code_t pick_separator(input logic bc0, input logic rsy,
                                           input logic ovf, input logic [1:0] bx);
   if (bc0)
      return K_BC0;          // Highest priority
   if (rsy)
      return K_RESYNC;
   if (ovf)
      return K_OVERFLOW;
   return bx_codes[bx];      // Rotating code
endfunction

function automatic link_data_t half_for_link(input logic [`GEM_DATA_BITS-1:0] d,
                                             input int idx);
   return (idx % 2 == 0) ? d[`GEM_LINK_BITS-1:0] : d[`GEM_DATA_BITS-1:`GEM_LINK_BITS];
endfunction

task automatic model_reset();
   int i;
   q_data.delete();
   q_sep.delete();
   q_due.delete();
   edge_n = 0;
   m_slot = 0;
   m_scnt = 0;
   m_link_en = '0;
   m_sdone = 1'b0;
   m_good = 0;
   for (i = 0; i < `GEM_N_LINKS; i++) begin
      m_crc[i]    = '0;
      exp_word[i] = `GEM_IDLE_WORD;
      exp_isk[i]  = `GEM_IDLE_ISK;
      exp_kchk[i] = 1'b0;
   end
   exp_sep          = K_BX0;
   exp_frame_ready  = 1'b0;
   exp_startup_done = 1'b0;
   exp_ready        = 1'b0;
endtask

// One rising edge: inputs are stable, model moves to the state after the edge
task automatic model_edge();
   logic       acc;
   logic       busy;
   logic       all_done;
   int         k;
   int         i;
   link_data_t half;
   acc = frame_valid_i && m_sdone && (m_slot == `GEM_FRAME_WORDS - 1);
   if (q_due.size() > 0 && edge_n > q_due[0] + `GEM_FRAME_WORDS - 1) begin
      void'(q_data.pop_front());   // All five words are out
      void'(q_sep.pop_front());
      void'(q_due.pop_front());
   end
   busy     = (q_due.size() > 0) && (edge_n >= q_due[0]);
   k        = busy ? edge_n - q_due[0] : 0;
   all_done = busy && (k == `GEM_FRAME_WORDS - 1) && (&m_link_en);
   for (i = 0; i < `GEM_N_LINKS; i++) begin
      exp_word[i] = `GEM_IDLE_WORD;
      exp_isk[i]  = `GEM_IDLE_ISK;
      exp_kchk[i] = 1'b0;
      if (busy && k == 0)
         m_crc[i] = '0;
      if (busy && m_link_en[i]) begin
         half       = half_for_link(q_data[0], i);
         exp_isk[i] = 2'b00;
         case (k)
            0: begin
               exp_word[i] = {half[7:0], q_sep[0]};
               exp_isk[i]  = 2'b01;    // Separator K-code
               exp_kchk[i] = 1'b1;
            end
            1:       exp_word[i] = half[23:8];
            2:       exp_word[i] = half[39:24];
            3:       exp_word[i] = half[55:40];
            default: exp_word[i] = {8'h00, m_crc[i]};
         endcase
         if (k < `GEM_FRAME_WORDS - 1)
            m_crc[i] = model_crc8(m_crc[i], exp_word[i]);
      end
   end
   if (busy)
      exp_sep = q_sep[0];
   if (force_not_ready_i)
      m_good = 0;
   else if (m_slot == `GEM_FRAME_WORDS - 1) begin
      if (!all_done)
         m_good = 0;                   // Idle period or a link down
      else if (m_good < `GEM_READY_FRAMES)
         m_good++;
   end
   if (acc) begin
      q_data.push_back(gem_data_i);
      q_sep.push_back(pick_separator(bc0_i, resync_i, overflow_i, bxn_lsbs_i));
      q_due.push_back(edge_n + 1);
      n_accepted++;
   end
   for (i = 0; i < `GEM_N_LINKS; i++)
      m_link_en[i] = (m_scnt >= `GEM_LINK_BASE + i * `GEM_LINK_STEP) && !link_reset_i[i];
   m_sdone = (m_scnt == `GEM_STARTUP_DONE);
   if (m_scnt < `GEM_STARTUP_DONE)
      m_scnt++;
   m_slot = (m_slot == `GEM_FRAME_WORDS - 1) ? 0 : m_slot + 1;
   edge_n++;
   exp_startup_done = m_sdone;
   exp_frame_ready  = m_sdone && (m_slot == `GEM_FRAME_WORDS - 1);
   exp_ready        = (m_good == `GEM_READY_FRAMES);
endtask

// ---------------------------------------------------------------------
// Compare tasks
// ---------------------------------------------------------------------
task automatic check_word(input string name, input link_word_t got, input link_word_t exp);
   if (got !== exp) begin
      err_word++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
   end
endtask

task automatic check_isk(input string name, input link_isk_t got, input link_isk_t exp);
   if (got !== exp) begin
      err_isk++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
   end
endtask

task automatic check_kcode(input string name, input k_code_t got, input k_code_t exp);
   if (got !== exp) begin
      err_kcode++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
   end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      err_ctrl++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
   end
endtask

`endif

// File: test/tb_gem_data_out.sv
`include "gem_tx_consts.svh"

module tb_gem_data_out;

   import gem_tx_pkg::*;

   localparam int RESET_CYCLES   = 16;
   localparam int RUN_CYCLES     = `GEM_STARTUP_DONE + 300 * `GEM_FRAME_WORDS;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + RUN_CYCLES + 200;  // Plus margin

   logic                                    clock_40 = 1'b0;
   logic                                    arst_n_i;
   logic                                    frame_valid_i;
   logic [`GEM_DATA_BITS-1:0]               gem_data_i;
   logic                                    overflow_i;
   logic                                    bc0_i;
   logic                                    resync_i;
   logic [1:0]                              bxn_lsbs_i;
   logic [`GEM_N_LINKS-1:0]                 link_reset_i;
   logic                                    force_not_ready_i;
   logic [`GEM_N_LINKS*`GEM_WORD_BITS-1:0]  tx_data_o;
   logic [`GEM_N_LINKS*`GEM_ISK_BITS-1:0]   tx_isk_o;
   logic                                    startup_done_o;
   logic                                    frame_ready_o;
   logic                                    ready_o;

   integer seed;
   int     wd_cycles      = 0;
   int     n_accepted     = 0;   // Frames taken by the model
   int     n_ready_cycles = 0;
   int     n_ready_drops  = 0;
   logic   prev_ready     = 1'b0;
   int     cyc;

   `include "tb_gem_model.svh"

   always #20 clock_40 = ~clock_40;   // 40 unit period

   gem_data_out gem_data_out_inst (
      .clock_40          (clock_40),
      .arst_n_i          (arst_n_i),
      .frame_valid_i     (frame_valid_i),
      .gem_data_i        (gem_data_i),
      .overflow_i        (overflow_i),
      .bc0_i             (bc0_i),
      .resync_i          (resync_i),
      .bxn_lsbs_i        (bxn_lsbs_i),
      .link_reset_i      (link_reset_i),
      .force_not_ready_i (force_not_ready_i),
      .tx_data_o         (tx_data_o),
      .tx_isk_o          (tx_isk_o),
      .startup_done_o    (startup_done_o),
      .frame_ready_o     (frame_ready_o),
      .ready_o           (ready_o)
   );

   // Watchdog
   always @(posedge clock_40) begin
      wd_cycles <= wd_cycles + 1;
      if (wd_cycles >= TIMEOUT_CYCLES) begin
         $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("sim failed");
         $finish;
      end
   end

   // New stimulus for one cycle, applied on the falling edge
   task automatic drive_inputs(input int c);
      logic [127:0] wide;
      logic [31:0]  r;
      logic         burst;
      burst = (c >= 600 && c < 800) || (c >= 1300 && c < 1500);  // Long good runs
      r     = $random(seed);
      wide  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      frame_valid_i     = burst || ((r % 100) < 80);
      gem_data_i        = wide[`GEM_DATA_BITS-1:0];
      bxn_lsbs_i        = r[9:8];
      bc0_i             = (($unsigned($random(seed)) % 23) == 0);  // Rare flags
      resync_i          = (($unsigned($random(seed)) % 29) == 0);
      overflow_i        = (($unsigned($random(seed)) % 17) == 0);
      link_reset_i      = (c >= 1400 && c < 1412) ? 4'b0100 : 4'b0000;
      force_not_ready_i = (c == 700);
   endtask

   task automatic check_outputs();
      int i;
      for (i = 0; i < `GEM_N_LINKS; i++) begin
         check_word($sformatf("tx_data_o[%0d]", i),
                    tx_data_o[i*`GEM_WORD_BITS +: `GEM_WORD_BITS], exp_word[i]);
         check_isk($sformatf("tx_isk_o[%0d]", i),
                   tx_isk_o[i*`GEM_ISK_BITS +: `GEM_ISK_BITS], exp_isk[i]);
         if (exp_kchk[i])
            check_kcode($sformatf("separator of link %0d", i),
                        k_code_t'(tx_data_o[i*`GEM_WORD_BITS +: 8]), exp_sep);
      end
      check_bit("frame_ready_o", frame_ready_o, exp_frame_ready);
      check_bit("startup_done_o", startup_done_o, exp_startup_done);
      check_bit("ready_o", ready_o, exp_ready);
      if (ready_o === 1'b1)
         n_ready_cycles++;
      if (prev_ready && ready_o !== 1'b1)
         n_ready_drops++;                 // Idle, force or link reset
      prev_ready = (ready_o === 1'b1);
   endtask

   initial begin
      seed              = 82;
      arst_n_i          = 1'b0;
      frame_valid_i     = 1'b0;
      gem_data_i        = '0;
      overflow_i        = 1'b0;
      bc0_i             = 1'b0;
      resync_i          = 1'b0;
      bxn_lsbs_i        = 2'b00;
      link_reset_i      = '0;
      force_not_ready_i = 1'b0;
      model_reset();
      repeat (RESET_CYCLES) begin
         @(posedge clock_40);
         model_reset();
         @(negedge clock_40);
         check_outputs();
      end
      arst_n_i = 1'b1;
      // ------------------------------------------------------------------
      // Random traffic, checked every cycle
      // ------------------------------------------------------------------
      for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
         drive_inputs(cyc);
         @(posedge clock_40);
         model_edge();
         @(negedge clock_40);
         check_outputs();
      end
      if (n_accepted == 0) begin
         err_other++;
         $display("No frame was accepted during the run");
      end
      if (n_ready_cycles == 0) begin
         err_other++;
         $display("ready_o never went high");
      end
      if (n_ready_drops < 2) begin
         err_other++;
         $display("ready_o dropped %0d times, fewer than the forced drops", n_ready_drops);
      end
      $display("errors: word=%0d isk=%0d kcode=%0d ctrl=%0d other=%0d (frames=%0d)",
               err_word, err_isk, err_kcode, err_ctrl, err_other, n_accepted);
      if (err_word + err_isk + err_kcode + err_ctrl + err_other == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// File: gem_data_out.f
+incdir+common
+incdir+test
common/gem_tx_pkg.sv
link/gem_link_crc8.sv
link/gem_link_framer.sv
hw/gem_frame_stage.sv
hw/gem_link_startup.sv
hw/gem_ready_monitor.sv
hw/gem_data_out.sv
test/tb_gem_data_out.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_gem_data_out
RTL_TOP    := gem_data_out
FILELIST   := gem_data_out.f
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := sim failed

INCDIRS    := $(filter +incdir+%,$(shell cat $(FILELIST)))
SRCS       := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
RTL_SRCS   := $(filter-out test/%,$(SRCS))
HDRS       := $(wildcard common/*.svh test/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) $(INCDIRS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
